// File: rtl/ahbPkg.sv
package ahbPkg;

    // ----------------------------------------
    // HTRANS codes with bit 1 marking a valid transfer
    // ----------------------------------------
    localparam logic [1:0] TransIdle   = 2'b00;
    localparam logic [1:0] TransBusy   = 2'b01;
    localparam logic [1:0] TransNonseq = 2'b10;
    localparam logic [1:0] TransSeq    = 2'b11;

    // HSIZE codes
    localparam logic [2:0] SizeByte = 3'b000;
    localparam logic [2:0] SizeHalf = 3'b001;
    localparam logic [2:0] SizeWord = 3'b010;

    localparam int DataWidth = 32;  // HADDR, HWDATA, HRDATA

    // Write strobe from transfer size and low address bits
    function automatic logic [3:0] byteLanes(input logic [2:0] size, input logic [1:0] addrLo);
        case (size)
            SizeByte: byteLanes = 4'b0001 << addrLo;
            SizeHalf: byteLanes = addrLo[1] ? 4'b1100 : 4'b0011;
            SizeWord: byteLanes = 4'b1111;
            default:  byteLanes = 4'b0000;  // Wider sizes unsupported
        endcase
    endfunction

endpackage

// File: rtl/socMapPkg.sv
package socMapPkg;

    // ----------------------------------------
    // Slave regions, decoded on bits 31:12
    // ----------------------------------------
    localparam logic [31:0] RamBase  = 32'h0000_0000;
    localparam logic [31:0] GpioBase = 32'h4000_0000;
    localparam logic [31:0] UartBase = 32'h4000_1000;

    localparam int RamWords = 256;  // 32-bit words

    // GPIO register offsets
    localparam logic [11:0] GpioDataOff = 12'h000;
    localparam logic [11:0] GpioEnOff   = 12'h004;
    localparam logic [11:0] GpioInOff   = 12'h008;  // Read only

    // UART register offsets and status bits
    localparam logic [11:0] UartDataOff = 12'h000;
    localparam logic [11:0] UartStatOff = 12'h004;
    localparam int StatTxBusy  = 0;
    localparam int StatRxValid = 1;

    localparam int BitPeriod = 8;  // Clocks per serial bit

    // Slave select codes
    localparam logic [1:0] SlaveRam  = 2'd0;
    localparam logic [1:0] SlaveGpio = 2'd1;
    localparam logic [1:0] SlaveUart = 2'd2;
    localparam logic [1:0] SlaveNone = 2'd3;

endpackage

// File: rtl/uartSerial.sv
`timescale 1ns/1ps

module uartSerial
(
    input  logic       clk,
    input  logic       RSTn,
    input  logic       txStart,
    input  logic [7:0] txByte,
    input  logic       RXD,
    output logic       TXD,
    output logic       txBusy,
    output logic [7:0] rxByte,
    output logic       rxDone
);
    import socMapPkg::*;

    localparam int CntBits = $clog2(BitPeriod);
    localparam logic [CntBits-1:0] CntLast = CntBits'(BitPeriod - 1);
    localparam logic [CntBits-1:0] CntMid  = CntBits'(BitPeriod / 2);

    logic [9:0]         txShift;  // Stop, data, start
    logic [3:0]         txBits;   // Bits still to send
    logic [CntBits-1:0] txCnt;
    logic               rxSyncA;
    logic               rxSyncB;
    logic               rxPrev;   // Edge detect
    logic               rxActive;
    logic [3:0]         rxBits;   // 0 start, 1 to 8 data, 9 stop
    logic [CntBits-1:0] rxCnt;

    // ----------------------------------------
    // Transmitter
    // ----------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            txShift <= '1;   // Line idles high
            txBits  <= '0;
            txCnt   <= '0;
        end
        else if (txStart)
        begin
            txShift <= {1'b1, txByte, 1'b0};
            txBits  <= 4'd10;
            txCnt   <= '0;
        end
        else if (txBits != 0)
        begin
            if (txCnt == CntLast)
            begin
                txCnt   <= '0;
                txShift <= {1'b1, txShift[9:1]};  // Fill with idle level
                txBits  <= txBits - 4'd1;
            end
            else
                txCnt <= txCnt + 1'b1;
        end
    end

    assign TXD    = txShift[0];
    assign txBusy = (txBits != 0);

    // ----------------------------------------
    // Receiver
    // ----------------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rxSyncA  <= 1'b1;
            rxSyncB  <= 1'b1;
            rxPrev   <= 1'b1;
            rxActive <= 1'b0;
            rxBits   <= '0;
            rxCnt    <= '0;
            rxByte   <= '0;
            rxDone   <= 1'b0;
        end
        else
        begin
            rxSyncA <= RXD;
            rxSyncB <= rxSyncA;
            rxPrev  <= rxSyncB;
            rxDone  <= 1'b0;
            if (!rxActive)
            begin
                if (rxPrev && !rxSyncB)  // Falling start edge
                begin
                    rxActive <= 1'b1;
                    rxBits   <= '0;
                    rxCnt    <= CntBits'(1);
                end
            end
            else
            begin
                if (rxCnt == CntLast)
                begin
                    rxCnt  <= '0;
                    rxBits <= rxBits + 4'd1;
                end
                else
                    rxCnt <= rxCnt + 1'b1;
                if (rxCnt == CntMid)  // Mid-bit sample
                begin
                    if (rxBits == 0 && rxSyncB)
                        rxActive <= 1'b0;   // Glitch, not a start bit
                    else if (rxBits == 9)
                    begin
                        rxActive <= 1'b0;
                        rxDone   <= rxSyncB;   // Framing error drops the byte
                    end
                    else if (rxBits != 0)
                        rxByte <= {rxSyncB, rxByte[7:1]};  // LSB first
                end
            end
        end
    end

    // Idle line after each frame relies on the shifter fill
    assert property (@(posedge clk) disable iff (!RSTn) !txBusy |-> TXD);

endmodule

// File: rtl/ahbInterconnect.sv
`timescale 1ns/1ps

module ahbInterconnect
(
    input  logic                         clk,
    input  logic                         RSTn,
    input  logic [ahbPkg::DataWidth-1:0] HADDR,
    input  logic [1:0]                   HTRANS,
    input  logic                         readyRam,
    input  logic                         readyGpio,
    input  logic                         readyUart,
    input  logic                         respRam,
    input  logic                         respGpio,
    input  logic                         respUart,
    input  logic [ahbPkg::DataWidth-1:0] rdataRam,
    input  logic [ahbPkg::DataWidth-1:0] rdataGpio,
    input  logic [ahbPkg::DataWidth-1:0] rdataUart,
    output logic                         selRam,
    output logic                         selGpio,
    output logic                         selUart,
    output logic                         HREADY,
    output logic                         HRESP,
    output logic [ahbPkg::DataWidth-1:0] HRDATA
);
    import ahbPkg::*;
    import socMapPkg::*;

    logic [1:0] addrSel;    // Address phase decode
    logic [1:0] dataSel;    // Data phase owner
    logic       xferValid;
    logic       errFirst;   // Error cycle 1 stalls
    logic       errSecond;  // Error cycle 2 completes

    assign xferValid = (HTRANS == TransNonseq) || (HTRANS == TransSeq);

    always_comb
    begin
        case (HADDR[31:12])
            RamBase[31:12]:  addrSel = SlaveRam;
            GpioBase[31:12]: addrSel = SlaveGpio;
            UartBase[31:12]: addrSel = SlaveUart;
            default:         addrSel = SlaveNone;
        endcase
    end

    assign selRam  = (addrSel == SlaveRam);
    assign selGpio = (addrSel == SlaveGpio);
    assign selUart = (addrSel == SlaveUart);

    // Owner and default responder advance together
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            dataSel   <= SlaveNone;
            errFirst  <= 1'b0;
            errSecond <= 1'b0;
        end
        else
        begin
            if (HREADY)
                dataSel <= addrSel;
            errFirst  <= HREADY && xferValid && (addrSel == SlaveNone);
            errSecond <= errFirst;
        end
    end

    // ----------------------------------------
    // Data phase response multiplexer
    // ----------------------------------------
    always_comb
    begin
        case (dataSel)
            SlaveRam:
            begin
                HREADY = readyRam;
                HRESP  = respRam;
                HRDATA = rdataRam;
            end
            SlaveGpio:
            begin
                HREADY = readyGpio;
                HRESP  = respGpio;
                HRDATA = rdataGpio;
            end
            SlaveUart:
            begin
                HREADY = readyUart;
                HRESP  = respUart;
                HRDATA = rdataUart;
            end
            default:
            begin
                HREADY = !errFirst;            // Low only in error cycle 1
                HRESP  = errFirst || errSecond;
                HRDATA = '0;                   // Unmapped reads return zero
            end
        endcase
    end

    // Stalled error cycle is always followed by the completing error cycle
    assert property (@(posedge clk) disable iff (!RSTn)
                     (HRESP && !HREADY) |=> (HRESP && HREADY));

endmodule

// File: rtl/ahbRam.sv
`timescale 1ns/1ps

module ahbRam
(
    input  logic                         clk,
    input  logic                         RSTn,
    input  logic                         sel,
    input  logic [ahbPkg::DataWidth-1:0] HADDR,
    input  logic [1:0]                   HTRANS,
    input  logic [2:0]                   HSIZE,
    input  logic                         HWRITE,
    input  logic [ahbPkg::DataWidth-1:0] HWDATA,
    input  logic                         HREADY,
    output logic                         HREADYOUT,
    output logic                         HRESP,
    output logic [ahbPkg::DataWidth-1:0] HRDATA
);
    import ahbPkg::*;
    import socMapPkg::*;

    localparam int AddrBits = $clog2(RamWords);

    logic [DataWidth-1:0] mem [RamWords];
    logic [AddrBits-1:0]  wordAddr;   // Data phase word index
    logic [3:0]           laneStb;    // Data phase write lanes
    logic                 writePend;  // Write owns the data phase

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            writePend <= 1'b0;
        else if (HREADY)
            writePend <= sel && HTRANS[1] && HWRITE;
    end

    // Address phase capture
    always_ff @(posedge clk)
    begin
        if (HREADY && sel && HTRANS[1])
        begin
            wordAddr <= HADDR[AddrBits+1:2];
            laneStb  <= byteLanes(HSIZE, HADDR[1:0]);
        end
    end

    // Strobed bytes land as the data phase ends
    always_ff @(posedge clk)
    begin
        if (writePend && HREADY)
            for (int i = 0; i < 4; i++)
                if (laneStb[i])
                    mem[wordAddr][8*i +: 8] <= HWDATA[8*i +: 8];
    end

    assign HRDATA    = mem[wordAddr];  // Zero wait read
    assign HREADYOUT = 1'b1;
    assign HRESP     = 1'b0;

    // Every write carries a supported size with at least one lane
    assert property (@(posedge clk) disable iff (!RSTn) writePend |-> (laneStb != 4'b0000));

endmodule

// File: rtl/ahbGpio.sv
`timescale 1ns/1ps

module ahbGpio
(
    input  logic                         clk,
    input  logic                         RSTn,
    input  logic                         sel,
    input  logic [ahbPkg::DataWidth-1:0] HADDR,
    input  logic [1:0]                   HTRANS,
    input  logic                         HWRITE,
    input  logic [ahbPkg::DataWidth-1:0] HWDATA,
    input  logic                         HREADY,
    input  logic [ahbPkg::DataWidth-1:0] gpioIn,
    output logic                         HREADYOUT,
    output logic                         HRESP,
    output logic [ahbPkg::DataWidth-1:0] HRDATA,
    output logic [ahbPkg::DataWidth-1:0] gpioOut,
    output logic [ahbPkg::DataWidth-1:0] gpioOutEn
);
    import ahbPkg::*;
    import socMapPkg::*;

    logic [11:0]          regOff;     // Data phase register offset
    logic                 writePend;
    logic [DataWidth-1:0] syncA;      // First sync stage
    logic [DataWidth-1:0] syncB;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            regOff    <= '0;
            writePend <= 1'b0;
            gpioOut   <= '0;
            gpioOutEn <= '0;
            syncA     <= '0;
            syncB     <= '0;
        end
        else
        begin
            syncA <= gpioIn;
            syncB <= syncA;
            if (HREADY)
            begin
                regOff    <= HADDR[11:0];
                writePend <= sel && HTRANS[1] && HWRITE;
            end
            if (writePend && HREADY)
            begin
                if (regOff == GpioDataOff)
                    gpioOut <= HWDATA;
                else if (regOff == GpioEnOff)
                    gpioOutEn <= HWDATA;
                // Input register ignores writes
            end
        end
    end

    always_comb
    begin
        case (regOff)
            GpioDataOff: HRDATA = gpioOut;
            GpioEnOff:   HRDATA = gpioOutEn;
            GpioInOff:   HRDATA = syncB;  // Synchronised pins
            default:     HRDATA = '0;
        endcase
    end

    assign HREADYOUT = 1'b1;
    assign HRESP     = 1'b0;

endmodule

// File: rtl/ahbUart.sv
`timescale 1ns/1ps

module ahbUart
(
    input  logic                         clk,
    input  logic                         RSTn,
    input  logic                         sel,
    input  logic [ahbPkg::DataWidth-1:0] HADDR,
    input  logic [1:0]                   HTRANS,
    input  logic                         HWRITE,
    input  logic [ahbPkg::DataWidth-1:0] HWDATA,
    input  logic                         HREADY,
    input  logic                         RXD,
    output logic                         HREADYOUT,
    output logic                         HRESP,
    output logic [ahbPkg::DataWidth-1:0] HRDATA,
    output logic                         TXD,
    output logic                         uartIrq
);
    import ahbPkg::*;
    import socMapPkg::*;

    logic [11:0] regOff;
    logic        readPend;   // Read owns the data phase
    logic        txPend;     // Data register write pending
    logic        txStart;
    logic        txBusy;
    logic [7:0]  rxByte;
    logic        rxDone;
    logic [7:0]  rxData;     // Last received byte
    logic        rxValid;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            regOff   <= '0;
            readPend <= 1'b0;
            txPend   <= 1'b0;
            rxData   <= '0;
            rxValid  <= 1'b0;
        end
        else
        begin
            if (HREADY)
            begin
                regOff   <= HADDR[11:0];
                readPend <= sel && HTRANS[1] && !HWRITE;
                txPend   <= sel && HTRANS[1] && HWRITE && (HADDR[11:0] == UartDataOff);
            end
            if (rxDone)
            begin
                rxData  <= rxByte;
                rxValid <= 1'b1;   // New byte wins over a clearing read
            end
            else if (readPend && HREADY && regOff == UartDataOff)
                rxValid <= 1'b0;
        end
    end

    // Stall a data write until the transmitter is idle
    assign HREADYOUT = !(txPend && txBusy);
    assign txStart   = txPend && !txBusy;
    assign HRESP     = 1'b0;
    assign uartIrq   = rxValid;

    always_comb
    begin
        HRDATA = '0;
        if (regOff == UartDataOff)
            HRDATA[7:0] = rxData;
        else if (regOff == UartStatOff)
        begin
            HRDATA[StatTxBusy]  = txBusy;
            HRDATA[StatRxValid] = rxValid;
        end
    end

    uartSerial serial
    (
        .clk     (clk),
        .RSTn    (RSTn),
        .txStart (txStart),
        .txByte  (HWDATA[7:0]),
        .RXD     (RXD),
        .TXD     (TXD),
        .txBusy  (txBusy),
        .rxByte  (rxByte),
        .rxDone  (rxDone)
    );

endmodule

// File: rtl/socPeriph.sv
`timescale 1ns/1ps

module socPeriph
(
    input  logic                         clk,
    input  logic                         RSTn,
    input  logic [ahbPkg::DataWidth-1:0] HADDR,
    input  logic [1:0]                   HTRANS,
    input  logic [2:0]                   HSIZE,
    input  logic                         HWRITE,
    input  logic [ahbPkg::DataWidth-1:0] HWDATA,
    input  logic [ahbPkg::DataWidth-1:0] gpioIn,
    input  logic                         RXD,
    output logic                         HREADY,
    output logic                         HRESP,
    output logic [ahbPkg::DataWidth-1:0] HRDATA,
    output logic [ahbPkg::DataWidth-1:0] gpioOut,
    output logic [ahbPkg::DataWidth-1:0] gpioOutEn,
    output logic                         TXD,
    output logic                         uartIrq
);
    import ahbPkg::*;

    // ----------------------------------------
    // Slave side wiring
    // ----------------------------------------
    logic                 selRam, selGpio, selUart;
    logic                 readyRam, readyGpio, readyUart;
    logic                 respRam, respGpio, respUart;
    logic [DataWidth-1:0] rdataRam, rdataGpio, rdataUart;

    ahbInterconnect bus
    (
        .clk(clk), .RSTn(RSTn), .HADDR(HADDR), .HTRANS(HTRANS),
        .readyRam(readyRam), .readyGpio(readyGpio), .readyUart(readyUart),
        .respRam(respRam), .respGpio(respGpio), .respUart(respUart),
        .rdataRam(rdataRam), .rdataGpio(rdataGpio), .rdataUart(rdataUart),
        .selRam(selRam), .selGpio(selGpio), .selUart(selUart),
        .HREADY(HREADY), .HRESP(HRESP), .HRDATA(HRDATA)
    );

    ahbRam ram
    (
        .clk(clk), .RSTn(RSTn), .sel(selRam), .HADDR(HADDR), .HTRANS(HTRANS),
        .HSIZE(HSIZE), .HWRITE(HWRITE), .HWDATA(HWDATA), .HREADY(HREADY),
        .HREADYOUT(readyRam), .HRESP(respRam), .HRDATA(rdataRam)
    );

    ahbGpio gpio
    (
        .clk(clk), .RSTn(RSTn), .sel(selGpio), .HADDR(HADDR), .HTRANS(HTRANS),
        .HWRITE(HWRITE), .HWDATA(HWDATA), .HREADY(HREADY), .gpioIn(gpioIn),
        .HREADYOUT(readyGpio), .HRESP(respGpio), .HRDATA(rdataGpio),
        .gpioOut(gpioOut), .gpioOutEn(gpioOutEn)
    );

    ahbUart uart
    (
        .clk(clk), .RSTn(RSTn), .sel(selUart), .HADDR(HADDR), .HTRANS(HTRANS),
        .HWRITE(HWRITE), .HWDATA(HWDATA), .HREADY(HREADY), .RXD(RXD),
        .HREADYOUT(readyUart), .HRESP(respUart), .HRDATA(rdataUart),
        .TXD(TXD), .uartIrq(uartIrq)
    );

endmodule

// File: tests/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
    output logic clk,
    output logic RSTn
);
    initial
    begin
        clk  = 1'b0;
        RSTn = 1'b0;              // Held low for two rising edges
        repeat (2) @(posedge clk);
        #1 RSTn = 1'b1;
    end

    always #2 clk = ~clk;         // 4 ns period

endmodule

// File: tests/tbSocPeriph.sv
`timescale 1ns/1ps

module tbSocPeriph;
    import ahbPkg::*;
    import socMapPkg::*;

    localparam int TimeoutCycles = 3000;  // Two UART frames dominate the six tests

    logic        clk;
    logic        RSTn;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic [2:0]  HSIZE;
    logic        HWRITE;
    logic [31:0] HWDATA;
    logic [31:0] gpioIn;
    logic        RXD;
    logic        HREADY;
    logic        HRESP;
    logic [31:0] HRDATA;
    logic [31:0] gpioOut;
    logic [31:0] gpioOutEn;
    logic        TXD;
    logic        uartIrq;

    logic [15:0] lfsr = 16'd52707;
    logic [31:0] ramModel [16];   // Expected contents of words 0 to 15
    int          stallCount;      // Cycles with HREADY low, last phase
    int          respCount;       // Cycles with HRESP high, last phase

    tbClock clockGen (.clk(clk), .RSTn(RSTn));

    socPeriph UUT
    (
        .clk(clk), .RSTn(RSTn), .HADDR(HADDR), .HTRANS(HTRANS), .HSIZE(HSIZE),
        .HWRITE(HWRITE), .HWDATA(HWDATA), .gpioIn(gpioIn), .RXD(RXD),
        .HREADY(HREADY), .HRESP(HRESP), .HRDATA(HRDATA), .gpioOut(gpioOut),
        .gpioOutEn(gpioOutEn), .TXD(TXD), .uartIrq(uartIrq)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Polynomial x^16 + x^14 + x^13 + x^11 + 1 stepped per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Bytes covered by the transfer, starting at the address offset
    function automatic logic [3:0] laneMask(input logic [2:0] size, input logic [1:0] lo);
        logic [3:0] span;
        if (size == SizeByte)
            span = 4'b0001;
        else if (size == SizeHalf)
            span = 4'b0011;
        else
            span = 4'b1111;
        return span << lo;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at time %0t: %s, got %h expected %h",
                     $time, msg, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Wait for the edge that ends the current phase
    task automatic awaitReady();
        stallCount = 0;
        respCount  = 0;
        @(negedge clk);           // Outputs settled mid-cycle
        while (!HREADY)
        begin
            stallCount++;
            if (HRESP)
                respCount++;
            @(negedge clk);
        end
        if (HRESP)
            respCount++;
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] data);
        HADDR  = addr;            // Address phase
        HTRANS = TransNonseq;
        HSIZE  = size;
        HWRITE = 1'b1;
        awaitReady();
        @(posedge clk);
        #1;
        HTRANS = TransIdle;       // Data phase
        HWRITE = 1'b0;
        HWDATA = data;
        awaitReady();
        @(posedge clk);
        #1;
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
        HADDR  = addr;
        HTRANS = TransNonseq;
        HSIZE  = SizeWord;
        HWRITE = 1'b0;
        awaitReady();
        @(posedge clk);
        #1;
        HTRANS = TransIdle;
        awaitReady();
        data = HRDATA;            // Sampled before the completing edge
        @(posedge clk);
        #1;
    endtask

    // Samples each bit centre after the start edge
    task automatic captureFrame(input logic [7:0] txByte);
        logic [9:0] expFrame;
        expFrame = {1'b1, txByte, 1'b0};  // Stop, data LSB first, start
        @(negedge TXD);
        repeat (BitPeriod / 2) @(negedge clk);
        for (int i = 0; i < 10; i++)
        begin
            checkValue(TXD, expFrame[i], $sformatf("TXD bit %0d of frame %h", i, txByte));
            if (i < 9)
                repeat (BitPeriod) @(negedge clk);
        end
    endtask

    task automatic sendSerial(input logic [7:0] rxByte);
        RXD = 1'b0;               // Start bit
        repeat (BitPeriod) @(posedge clk);
        #1;
        for (int i = 0; i < 8; i++)
        begin
            RXD = rxByte[i];
            repeat (BitPeriod) @(posedge clk);
            #1;
        end
        RXD = 1'b1;               // Stop bit and idle level
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic resetDefaults();
        logic [31:0] rd;
        checkValue(HREADY, 1'b1, "HREADY after reset");
        checkValue(HRESP, 1'b0, "HRESP after reset");
        checkValue(TXD, 1'b1, "TXD idle after reset");
        checkValue(gpioOut, 32'h0, "gpioOut after reset");
        checkValue(gpioOutEn, 32'h0, "gpioOutEn after reset");
        checkValue(uartIrq, 1'b0, "uartIrq after reset");
        busRead(UartBase + UartStatOff, rd);
        checkValue(rd, 32'h0, "UART status after reset");
    endtask

    task automatic ramReadback();
        logic [31:0] data;
        logic [31:0] rd;
        logic [3:0]  idx;
        logic [1:0]  lo;
        logic [2:0]  size;
        logic [3:0]  mask;
        for (int i = 0; i < 16; i++)
        begin
            ramModel[i] = randBits(32);
            busWrite(RamBase + 4 * i, SizeWord, ramModel[i]);
        end
        for (int k = 0; k < 8; k++)   // Partial overwrites
        begin
            idx  = randBits(4);
            lo   = randBits(2);
            size = randBits(1) ? SizeHalf : SizeByte;
            if (size == SizeHalf)
                lo[0] = 1'b0;         // Halfword aligned
            data = randBits(32);
            mask = laneMask(size, lo);
            for (int b = 0; b < 4; b++)
                if (mask[b])
                    ramModel[idx][8*b +: 8] = data[8*b +: 8];
            busWrite(RamBase + {idx, lo}, size, data);
        end
        for (int i = 0; i < 16; i++)
        begin
            busRead(RamBase + 4 * i, rd);
            checkValue(rd, ramModel[i], $sformatf("RAM word %0d", i));
        end
    endtask

    task automatic gpioLoopback();
        logic [31:0] outVal;
        logic [31:0] enVal;
        logic [31:0] inVal;
        logic [31:0] rd;
        outVal = randBits(32);
        enVal  = randBits(32);
        inVal  = randBits(32);
        busWrite(GpioBase + GpioDataOff, SizeWord, outVal);
        checkValue(gpioOut, outVal, "gpioOut after data write");
        busWrite(GpioBase + GpioEnOff, SizeWord, enVal);
        checkValue(gpioOutEn, enVal, "gpioOutEn after enable write");
        gpioIn = inVal;
        repeat (3) @(posedge clk);    // Two flop synchroniser
        #1;
        busRead(GpioBase + GpioInOff, rd);
        checkValue(rd, inVal, "GPIO input register");
    endtask

    task automatic uartTransmit();
        logic [7:0] first;
        logic [7:0] second;
        first  = randBits(8);
        second = randBits(8);
        fork
            begin
                busWrite(UartBase + UartDataOff, SizeWord, {24'h0, first});
                busWrite(UartBase + UartDataOff, SizeWord, {24'h0, second});
                checkValue(stallCount != 0, 1'b1, "HREADY low on second UART write");
            end
            begin
                captureFrame(first);
                captureFrame(second);
            end
        join
    endtask

    task automatic uartReceive();
        logic [7:0]  rxByte;
        logic [31:0] rd;
        int          waited;
        rxByte = randBits(8);
        sendSerial(rxByte);
        waited = 0;
        @(negedge clk);
        while (!uartIrq)              // Bounded wait for the stop bit sample
        begin
            waited++;
            if (waited > 2 * BitPeriod)
            begin
                $display("uartIrq never rose after a received frame");
                $display("Test failed");
                $fatal(1, "Receive timeout");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        busRead(UartBase + UartStatOff, rd);
        checkValue(rd, 32'h1 << StatRxValid, "UART status after receive");
        busRead(UartBase + UartDataOff, rd);
        checkValue(rd, {24'h0, rxByte}, "UART received byte");
        @(negedge clk);
        checkValue(uartIrq, 1'b0, "uartIrq after data read");
        @(posedge clk);
        #1;
    endtask

    task automatic unmappedAccess();
        logic [31:0] rd;
        busRead(32'h2000_0000, rd);
        checkValue(rd, 32'h0, "unmapped read data");
        checkValue(respCount, 2, "HRESP cycles on unmapped read");
        busWrite(32'h2000_0000, SizeWord, randBits(32));
        checkValue(respCount, 2, "HRESP cycles on unmapped write");
        busRead(RamBase, rd);
        checkValue(rd, ramModel[0], "RAM word 0 after unmapped write");
    endtask

    // ----------------------------------------
    // Sequence and watchdog
    // ----------------------------------------
    initial
    begin
        HADDR  = '0;
        HTRANS = TransIdle;
        HSIZE  = SizeWord;
        HWRITE = 1'b0;
        HWDATA = '0;
        gpioIn = '0;
        RXD    = 1'b1;                // Serial line idles high
        @(posedge RSTn);
        @(posedge clk);
        #1;
        resetDefaults();
        ramReadback();
        gpioLoopback();
        uartTransmit();
        uartReceive();
        unmappedAccess();
        $display("Test passed");
        $finish;
    end

    initial
    begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", TimeoutCycles);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: src.f
rtl/ahbPkg.sv
rtl/socMapPkg.sv
rtl/uartSerial.sv
rtl/ahbInterconnect.sv
rtl/ahbRam.sv
rtl/ahbGpio.sv
rtl/ahbUart.sv
rtl/socPeriph.sv
tests/tbClock.sv
tests/tbSocPeriph.sv
